// ==== sim.f ====
src/vec_pkg.sv
src/vec_bank.sv
src/vec_axil_slave.sv
src/vec_sequencer.sv
src/vec_lane_alu.sv
src/vec_top.sv
bench/vec_tb.sv

// ==== Bender.yml ====
package:
  name: vec_lane

sources:
  - src/vec_pkg.sv
  - src/vec_bank.sv
  - src/vec_axil_slave.sv
  - src/vec_sequencer.sv
  - src/vec_lane_alu.sv
  - src/vec_top.sv
  - target: test
    files:
      - bench/vec_tb.sv

// ==== bench/vec_tb.sv ====
`timescale 1ns/100ps

module vec_tb import vec_pkg::*; ();

    localparam int PERIOD = 100;
    localparam int DRV    = 10;                 // input skew after the rising edge
    localparam int NROWS  = 6;
    localparam int WD_CYC = NROWS * 400 + 200;  // watchdog budget in clock periods

    // one run per row
    typedef struct packed {
        mode_t      mode;
        logic       carry_pat;  // a all ones and b one, forces carry-out on add
        logic [3:0] b_stall;    // cycles bready stays low once bvalid is up
        logic [3:0] r_stall;    // same for rready
    } row_t;

    logic                    clk;
    logic                    rst;
    logic [AXI_ADDR_W-1:0]   s_awaddr;
    logic                    s_awvalid;
    logic                    s_awready;
    logic [AXI_DATA_W-1:0]   s_wdata;
    logic [AXI_DATA_W/8-1:0] s_wstrb;
    logic                    s_wvalid;
    logic                    s_wready;
    logic [1:0]              s_bresp;
    logic                    s_bvalid;
    logic                    s_bready;
    logic [AXI_ADDR_W-1:0]   s_araddr;
    logic                    s_arvalid;
    logic                    s_arready;
    logic [AXI_DATA_W-1:0]   s_rdata;
    logic [1:0]              s_rresp;
    logic                    s_rvalid;
    logic                    s_rready;

    row_t   rows [NROWS];
    elem_t  a_vec [DEPTH];  // operands as loaded, model input
    elem_t  b_vec [DEPTH];
    integer seed = 32'h433875f2;
    int     errors = 0;

    vec_top #(.DEPTH(DEPTH)) dut_i (
        .clk(clk), .rst(rst),
        .s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
        .s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid),
        .s_wready_o(s_wready), .s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid),
        .s_bready_i(s_bready), .s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid),
        .s_arready_o(s_arready), .s_rdata_o(s_rdata), .s_rresp_o(s_rresp),
        .s_rvalid_o(s_rvalid), .s_rready_i(s_rready)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("timeout: run did not finish within %0d clock periods", WD_CYC);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called and returns at posedge + DRV, outputs sampled at negedge where they are settled
    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        logic hs;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do begin
            @(negedge clk) hs = s_awready && s_wready;  // both ready in the same cycle
            @(posedge clk) #DRV;
        end while (!hs);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        repeat (stall) begin
            @(negedge clk) check("bvalid held under stall", s_bvalid, 1'b1);
            @(posedge clk) #DRV;
        end
        s_bready = 1'b1;
        @(negedge clk) check("bvalid", s_bvalid, 1'b1);
        resp = s_bresp;
        @(posedge clk) #DRV s_bready = 1'b0;
        @(negedge clk) check("bvalid after response", s_bvalid, 1'b0); // only one response
        @(posedge clk) #DRV;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        logic hs;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        do begin
            @(negedge clk) hs = s_arready;
            @(posedge clk) #DRV;
        end while (!hs);
        s_arvalid = 1'b0;
        repeat (stall) begin
            @(negedge clk) check("rvalid held under stall", s_rvalid, 1'b1);
            @(posedge clk) #DRV;
        end
        s_rready = 1'b1;
        @(negedge clk) check("rvalid", s_rvalid, 1'b1); // first negedge after accept when no stall
        data = s_rdata;
        resp = s_rresp;
        @(posedge clk) #DRV s_rready = 1'b0;
        @(negedge clk) check("rvalid after response", s_rvalid, 1'b0);
        @(posedge clk) #DRV;
    endtask

    // {carry, data} straight from the element rules
    function automatic logic [32:0] expect_res(input mode_t mode, input elem_t a, input elem_t b);
        case (mode)
            MODE_ADD:    return {(a + b) < a, a + b};   // wrapped sum below a means carry-out
            MODE_SUB:    return {a < b, a - b};          // borrow where a < b unsigned
            MODE_PASS_B: return {1'b0, b};
            default:     return {1'b0, a};
        endcase
    endfunction

    initial begin
        logic [1:0]  resp;
        logic [31:0] rd;
        logic [32:0] exp;
        row_t        r;
        //        mode         carry  bstall rstall
        rows[0] = {MODE_ADD,    1'b0, 4'd0, 4'd0};
        rows[1] = {MODE_ADD,    1'b1, 4'd0, 4'd0};
        rows[2] = {MODE_SUB,    1'b0, 4'd0, 4'd0};
        rows[3] = {MODE_PASS_B, 1'b0, 4'd0, 4'd0};
        rows[4] = {MODE_PASS_A, 1'b0, 4'd0, 4'd0};
        rows[5] = {MODE_SUB,    1'b0, 4'd2, 4'd3}; // back-pressure on both channels
        rst       = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '1;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (2) @(posedge clk);
        #DRV rst = 1'b1;
        axil_read(CTRL_ADDR, 0, rd, resp);
        check("ctrl after reset", rd, 32'h0);
        check("rresp ctrl", resp, 2'b00);
        axil_read(A_BASE, 0, rd, resp);     // operand windows are write only
        check("rdata write-only", rd, 32'h0);
        check("rresp write-only", resp, 2'b10);
        for (int k = 0; k < NROWS; k++) begin
            r = rows[k];
            for (int i = 0; i < DEPTH; i++) begin
                a_vec[i] = r.carry_pat ? '1 : $random(seed);
                b_vec[i] = r.carry_pat ? 32'd1 : $random(seed);
                axil_write(AXI_ADDR_W'(A_BASE + 4 * i), a_vec[i], r.b_stall, resp);
                check("bresp operand a", resp, 2'b00);
                axil_write(AXI_ADDR_W'(B_BASE + 4 * i), b_vec[i], r.b_stall, resp);
                check("bresp operand b", resp, 2'b00);
            end
            axil_write(CTRL_ADDR, 32'h100 | 32'(r.mode), r.b_stall, resp); // mode plus start
            check("bresp start", resp, 2'b00);
            // last element is read late in the run, so a write that slipped in would show
            axil_write(AXI_ADDR_W'(A_BASE + 4 * (DEPTH - 1)), ~a_vec[DEPTH-1], r.b_stall, resp);
            check("bresp write while busy", resp, 2'b10);
            axil_read(CTRL_ADDR, r.r_stall, rd, resp);
            check("ctrl during run", rd, 32'h100 | 32'(r.mode)); // busy up, old done cleared
            rd = '0;
            while (!rd[CTRL_DONE_BIT]) begin
                axil_read(CTRL_ADDR, r.r_stall, rd, resp);
            end
            check("ctrl after run", rd, 32'h200 | 32'(r.mode));
            axil_write(RES_BASE, 32'hdeadbeef, r.b_stall, resp);
            check("bresp write to result", resp, 2'b10);
            for (int i = 0; i < DEPTH; i++) begin
                exp = expect_res(r.mode, a_vec[i], b_vec[i]);
                axil_read(AXI_ADDR_W'(RES_BASE + 4 * i), r.r_stall, rd, resp);
                check($sformatf("row %0d res[%0d]", k, i), rd, exp[31:0]);
                check("rresp result", resp, 2'b00);
                axil_read(AXI_ADDR_W'(CARRY_BASE + 4 * i), r.r_stall, rd, resp);
                check($sformatf("row %0d carry[%0d]", k, i), rd, {31'b0, exp[32]});
                check("rresp carry", resp, 2'b00);
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src/vec_top.sv ====
`timescale 1ns/100ps

module vec_top import vec_pkg::*; #(
    parameter int DEPTH = vec_pkg::DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [AXI_DATA_W-1:0]   s_wdata_i,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  logic [AXI_ADDR_W-1:0]   s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [AXI_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i
);

    logic             a_we;
    logic             b_we;
    logic [IDX_W-1:0] op_idx;     // host write index into a or b
    elem_t            op_data;
    logic [IDX_W-1:0] res_idx;    // host read index into results
    result_t          res_rdata;
    mode_t            mode;
    logic             start;
    logic             busy;
    logic             done;
    logic [IDX_W-1:0] rd_idx;     // run read index, both operand banks
    logic             res_we;
    logic [IDX_W-1:0] res_widx;
    elem_t            a_rdata;
    elem_t            b_rdata;
    result_t          alu_res;

    vec_axil_slave u_slave (
        .clk         (clk),
        .rst         (rst),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .a_we_o      (a_we),
        .b_we_o      (b_we),
        .op_idx_o    (op_idx),
        .op_data_o   (op_data),
        .res_idx_o   (res_idx),
        .res_rdata_i (res_rdata),
        .mode_o      (mode),
        .start_o     (start),
        .busy_i      (busy),
        .done_i      (done)
    );

    // operand banks, written by the host and read by the run
    vec_bank #(.word_t(elem_t), .DEPTH(DEPTH)) bank_a (
        .clk     (clk),
        .we_i    (a_we),
        .waddr_i (op_idx),
        .wdata_i (op_data),
        .raddr_i (rd_idx),
        .rdata_o (a_rdata)
    );

    vec_bank #(.word_t(elem_t), .DEPTH(DEPTH)) bank_b (
        .clk     (clk),
        .we_i    (b_we),
        .waddr_i (op_idx),
        .wdata_i (op_data),
        .raddr_i (rd_idx),
        .rdata_o (b_rdata)
    );

    // results carry the flag alongside the data
    vec_bank #(.word_t(result_t), .DEPTH(DEPTH)) bank_res (
        .clk     (clk),
        .we_i    (res_we),
        .waddr_i (res_widx),
        .wdata_i (alu_res),
        .raddr_i (res_idx),
        .rdata_o (res_rdata)
    );

    vec_sequencer #(.DEPTH(DEPTH)) u_seq (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start),
        .rd_idx_o (rd_idx),
        .wr_en_o  (res_we),
        .wr_idx_o (res_widx),
        .busy_o   (busy),
        .done_o   (done)
    );

    vec_lane_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .mode_i (mode),
        .a_i    (a_rdata),
        .b_i    (b_rdata),
        .res_o  (alu_res)
    );

endmodule

// ==== src/vec_lane_alu.sv ====
`timescale 1ns/100ps

module vec_lane_alu import vec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  mode_t   mode_i,
    input  elem_t   a_i,
    input  elem_t   b_i,
    output result_t res_o
);

    logic [DATA_W:0] sum;   // msb is carry-out
    logic [DATA_W:0] diff;  // msb is borrow, set when a < b unsigned

    assign sum  = {1'b0, a_i} + {1'b0, b_i};
    assign diff = {1'b0, a_i} - {1'b0, b_i};

    always_ff @(posedge clk) begin
        if (!rst) begin
            res_o <= '0;
        end else begin
            case (mode_i)
                MODE_ADD:    res_o <= '{data: sum[DATA_W-1:0], carry: sum[DATA_W]};
                MODE_SUB:    res_o <= '{data: diff[DATA_W-1:0], carry: diff[DATA_W]};
                MODE_PASS_B: res_o <= '{data: b_i, carry: 1'b0};
                default:     res_o <= '{data: a_i, carry: 1'b0}; // pass a
            endcase
        end
    end

endmodule

// ==== src/vec_sequencer.sv ====
`timescale 1ns/100ps

module vec_sequencer import vec_pkg::*; #(
    parameter int DEPTH = vec_pkg::DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    output logic [IDX_W-1:0] rd_idx_o,  // operand bank read index
    output logic             wr_en_o,   // result bank write
    output logic [IDX_W-1:0] wr_idx_o,
    output logic             busy_o,
    output logic             done_o
);

    localparam int CW   = $clog2(DEPTH + 2);
    localparam int LAST = DEPTH + 1;    // busy spans counts 0 .. DEPTH+1

    logic [CW-1:0]    cnt_q;
    logic             busy_q;
    logic             done_q;
    logic             issue;            // a read index goes out this cycle
    logic             issue_d1_q;       // operand data at the alu
    logic             issue_d2_q;       // alu result ready for the bank
    logic [IDX_W-1:0] idx_d1_q;
    logic [IDX_W-1:0] idx_d2_q;

    assign issue    = busy_q && (cnt_q < CW'(DEPTH));
    assign rd_idx_o = IDX_W'(cnt_q);

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start_i && !busy_q) begin
            cnt_q  <= '0;
            busy_q <= 1'b1;
            done_q <= 1'b0;             // done holds until the next run
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CW'(LAST)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // two stages match bank read latency plus the alu register
    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_d1_q <= 1'b0;
            issue_d2_q <= 1'b0;
        end else begin
            issue_d1_q <= issue;
            issue_d2_q <= issue_d1_q;
        end
    end

    always_ff @(posedge clk) begin
        idx_d1_q <= rd_idx_o;
        idx_d2_q <= idx_d1_q;
    end

    assign wr_en_o  = issue_d2_q;
    assign wr_idx_o = idx_d2_q;
    assign busy_o   = busy_q;
    assign done_o   = done_q;

endmodule

// ==== src/vec_axil_slave.sv ====
`timescale 1ns/100ps

module vec_axil_slave import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // write address, data and response
    input  logic [AXI_ADDR_W-1:0]   s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [AXI_DATA_W-1:0]   s_wdata_i,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb_i,   // byte strobes ignored, writes are word wide
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    // read address and data
    input  logic [AXI_ADDR_W-1:0]   s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [AXI_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    // operand bank write ports
    output logic                    a_we_o,
    output logic                    b_we_o,
    output logic [IDX_W-1:0]        op_idx_o,
    output elem_t                   op_data_o,
    // result bank read port
    output logic [IDX_W-1:0]        res_idx_o,
    input  result_t                 res_rdata_i,
    // run control
    output mode_t                   mode_o,
    output logic                    start_o,
    input  logic                    busy_i,
    input  logic                    done_i
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam int         WIN_LSB     = IDX_W + 2; // each window spans 2**IDX_W words

    // what the r channel returns for the accepted read
    typedef enum logic [1:0] {
        SEL_RES,
        SEL_CARRY,
        SEL_CTRL,
        SEL_ERR
    } rsel_t;

    // address falls in the element window starting at base
    function automatic logic in_win(input logic [AXI_ADDR_W-1:0] addr,
                                    input logic [AXI_ADDR_W-1:0] base);
        return addr[AXI_ADDR_W-1:WIN_LSB] == base[AXI_ADDR_W-1:WIN_LSB];
    endfunction

    logic                  aw_hs;     // aw and w taken together
    logic                  wr_a;
    logic                  wr_b;
    logic                  wr_ctrl;
    logic                  wr_ok;     // mapped, writable and idle
    logic                  bvalid_q;
    logic [1:0]            bresp_q;
    mode_t                 mode_q;

    logic                  ar_hs;
    rsel_t                 rsel_d;
    rsel_t                 rsel_q;    // read-select tag, one cycle behind the address
    logic [IDX_W-1:0]      ridx_q;    // index of the pending read
    logic [AXI_DATA_W-1:0] ctrl_word;
    logic [AXI_DATA_W-1:0] ctrl_q;    // status sampled at acceptance
    logic                  rvalid_q;

    // write path
    assign aw_hs       = s_awvalid_i && s_wvalid_i && !bvalid_q;
    assign s_awready_o = aw_hs;
    assign s_wready_o  = aw_hs;

    assign wr_a    = in_win(s_awaddr_i, A_BASE);
    assign wr_b    = in_win(s_awaddr_i, B_BASE);
    assign wr_ctrl = s_awaddr_i[AXI_ADDR_W-1:2] == CTRL_ADDR[AXI_ADDR_W-1:2];
    assign wr_ok   = (wr_a || wr_b || wr_ctrl) && !busy_i; // nothing changes during a run

    assign a_we_o    = aw_hs && wr_ok && wr_a;
    assign b_we_o    = aw_hs && wr_ok && wr_b;
    assign op_idx_o  = s_awaddr_i[WIN_LSB-1:2];
    assign op_data_o = s_wdata_i;
    assign start_o   = aw_hs && wr_ok && wr_ctrl && s_wdata_i[CTRL_START_BIT]; // single cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            bvalid_q <= 1'b0;
            mode_q   <= MODE_ADD;
        end else begin
            if (aw_hs) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (aw_hs && wr_ok && wr_ctrl) begin
                mode_q <= mode_t'(s_wdata_i[$bits(mode_t)-1:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = bresp_q;
    assign mode_o     = mode_q;

    // read path
    assign s_arready_o = !rvalid_q;
    assign ar_hs       = s_arvalid_i && !rvalid_q;

    always_comb begin
        if (in_win(s_araddr_i, RES_BASE)) begin
            rsel_d = SEL_RES;
        end else if (in_win(s_araddr_i, CARRY_BASE)) begin
            rsel_d = SEL_CARRY;
        end else if (s_araddr_i[AXI_ADDR_W-1:2] == CTRL_ADDR[AXI_ADDR_W-1:2]) begin
            rsel_d = SEL_CTRL;
        end else begin
            rsel_d = SEL_ERR; // operand windows are write only
        end
    end

    always_comb begin
        ctrl_word                 = '0;
        ctrl_word[1:0]            = mode_q;
        ctrl_word[CTRL_BUSY_BIT]  = busy_i;
        ctrl_word[CTRL_DONE_BIT]  = done_i;
    end

    // bank keeps re-reading the pending index so data holds under rready stall
    assign res_idx_o = ar_hs ? s_araddr_i[WIN_LSB-1:2] : ridx_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;        // bank data lands next cycle
        end else if (s_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rsel_q <= rsel_d;
            ridx_q <= s_araddr_i[WIN_LSB-1:2];
            ctrl_q <= ctrl_word;
        end
    end

    always_comb begin
        case (rsel_q)
            SEL_RES:   s_rdata_o = res_rdata_i.data;
            SEL_CARRY: s_rdata_o = AXI_DATA_W'(res_rdata_i.carry);
            SEL_CTRL:  s_rdata_o = ctrl_q;
            default:   s_rdata_o = '0;
        endcase
    end

    assign s_rresp_o  = (rsel_q == SEL_ERR) ? RESP_SLVERR : RESP_OKAY;
    assign s_rvalid_o = rvalid_q;

endmodule

// ==== src/vec_bank.sv ====
`timescale 1ns/100ps

module vec_bank import vec_pkg::*; #(
    parameter type word_t = elem_t,
    parameter int  DEPTH  = vec_pkg::DEPTH
) (
    input  logic             clk,
    input  logic             we_i,     // write port
    input  logic [IDX_W-1:0] waddr_i,
    input  word_t            wdata_i,
    input  logic [IDX_W-1:0] raddr_i,  // read port, one cycle latency
    output word_t            rdata_o
);

    // only the low index bits select a word when the bank is shallower than the map
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i[AW-1:0]] <= wdata_i;
        end
        // no bypass, the run never reads and writes one index in the same cycle
        rdata_o <= mem[raddr_i[AW-1:0]];
    end

endmodule

// ==== src/vec_pkg.sv ====
package vec_pkg;

    // element and run geometry
    parameter int DATA_W = 32;     // one vector element
    parameter int DEPTH  = 16;     // elements per run
    parameter int IDX_W  = 4;      // element index width

    // axi4-lite bus widths
    parameter int AXI_ADDR_W = 12;
    parameter int AXI_DATA_W = 32;

    // register map, byte addresses, one 32-bit word per element
    parameter logic [AXI_ADDR_W-1:0] A_BASE     = 12'h000; // operand a, write only
    parameter logic [AXI_ADDR_W-1:0] B_BASE     = 12'h040; // operand b, write only
    parameter logic [AXI_ADDR_W-1:0] RES_BASE   = 12'h080; // result data, read only
    parameter logic [AXI_ADDR_W-1:0] CTRL_ADDR  = 12'h0C0; // control and status
    parameter logic [AXI_ADDR_W-1:0] CARRY_BASE = 12'h100; // carry flag in bit 0, read only

    // ctrl register fields, mode sits in bits 1:0
    parameter int CTRL_START_BIT = 8; // write side
    parameter int CTRL_BUSY_BIT  = 8; // read side
    parameter int CTRL_DONE_BIT  = 9; // read side

    // element operation
    typedef enum logic [1:0] {
        MODE_ADD    = 2'd0, // a + b
        MODE_SUB    = 2'd1, // a - b
        MODE_PASS_B = 2'd2,
        MODE_PASS_A = 2'd3
    } mode_t;

    typedef logic [DATA_W-1:0] elem_t;

    // result word, carry is carry-out on add and borrow on sub
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              carry;
    } result_t;

endpackage
